// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    localparam int data_bits   = 32;
    localparam int reg_no_bits = 4;
    localparam int imm_bits    = 16;
    localparam int op1_bits    = 6;
    localparam int op2_bits    = 8;
    localparam int ledr_bits   = 10;
    localparam int hex_bits    = 24;
    localparam int key_bits    = 4;
    localparam int sw_bits     = 10;

    localparam logic [data_bits-1:0] inst_size       = 32'd4;
    localparam logic [hex_bits-1:0]  hex_reset_value = 24'hFEDEAD;

    // Memory-mapped devices, all in the top 4 KB page
    localparam logic [data_bits-1:0] addr_hex  = 32'hFFFFF000;
    localparam logic [data_bits-1:0] addr_ledr = 32'hFFFFF020;
    localparam logic [data_bits-1:0] addr_key  = 32'hFFFFF080;
    localparam logic [data_bits-1:0] addr_sw   = 32'hFFFFF090;

    typedef enum logic [op1_bits-1:0] {
        op1_alur = 6'h00,
        op1_beq  = 6'h08,
        op1_blt  = 6'h09,
        op1_ble  = 6'h0A,
        op1_bne  = 6'h0B,
        op1_jal  = 6'h0C,
        op1_lw   = 6'h12,
        op1_sw   = 6'h1A,
        op1_addi = 6'h20,
        op1_andi = 6'h24,
        op1_ori  = 6'h25,
        op1_xori = 6'h26
    } op1_t;

    typedef enum logic [op2_bits-1:0] {
        op2_eq   = 8'h08,
        op2_lt   = 8'h09,
        op2_le   = 8'h0A,
        op2_ne   = 8'h0B,
        op2_add  = 8'h20,
        op2_and  = 8'h24,
        op2_or   = 8'h25,
        op2_xor  = 8'h26,
        op2_sub  = 8'h28,
        op2_nand = 8'h2C,
        op2_nor  = 8'h2D,
        op2_nxor = 8'h2E,
        op2_rshf = 8'h30,
        op2_lshf = 8'h31
    } op2_t;

    typedef enum logic [1:0] {
        wb_pc  = 2'd0,  // Return address of JAL
        wb_mem = 2'd1,
        wb_alu = 2'd2
    } wb_src_t;

    // Same word seen as register format or immediate format
    typedef union packed {
        struct packed {
            op1_t                   op1;
            op2_t                   op2;
            logic [5:0]             unused;
            logic [reg_no_bits-1:0] rd;
            logic [reg_no_bits-1:0] rs;
            logic [reg_no_bits-1:0] rt;
        } rtype;
        struct packed {
            op1_t                   op1;
            logic [1:0]             unused;
            logic [imm_bits-1:0]    imm;
            logic [reg_no_bits-1:0] rs;
            logic [reg_no_bits-1:0] rt;
        } itype;
    } instr_t;

endpackage

// ==== logic/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if;
    logic [cpu_pkg::data_bits-1:0] addr;
    logic [cpu_pkg::data_bits-1:0] wdata;
    logic                          we;     // Write lands on the next rising edge
    logic [cpu_pkg::data_bits-1:0] rdata;  // Zero for unmapped addresses

    modport master (output addr, output wdata, output we, input rdata);
    modport device (input addr, input wdata, input we, output rdata);
endinterface

// ==== logic/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpu_pkg::reg_no_bits-1:0] rs,
    input  logic [cpu_pkg::reg_no_bits-1:0] rt,
    output logic [cpu_pkg::data_bits-1:0]   rs_val,
    output logic [cpu_pkg::data_bits-1:0]   rt_val,
    input  logic                            we,
    input  logic [cpu_pkg::reg_no_bits-1:0] wdst,
    input  logic [cpu_pkg::data_bits-1:0]   wdata
);

    localparam int num_regs = 2 ** cpu_pkg::reg_no_bits;

    logic [cpu_pkg::data_bits-1:0] regs [num_regs];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wdst != '0) begin
            regs[wdst] <= wdata;
        end
    end

    // A write in this cycle shows through to the reads
    assign rs_val = (rs == '0) ? '0 : (we && wdst == rs) ? wdata : regs[rs];
    assign rt_val = (rt == '0) ? '0 : (we && wdst == rt) ? wdata : regs[rt];
endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
    parameter int                            imem_addr_bits = 16,
    parameter logic [cpu_pkg::data_bits-1:0] start_pc       = 32'h100
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          redirect,
    input  logic [cpu_pkg::data_bits-1:0] target,
    input  logic                          prog_we,
    input  logic [cpu_pkg::data_bits-1:0] prog_addr,
    input  logic [cpu_pkg::data_bits-1:0] prog_data,
    output cpu_pkg::instr_t               inst,
    output logic [cpu_pkg::data_bits-1:0] next_pc,
    output logic                          valid
);

    localparam int imem_words = 2 ** (imem_addr_bits - 2);

    logic [cpu_pkg::data_bits-1:0] imem [imem_words];
    logic [cpu_pkg::data_bits-1:0] pc;
    logic [cpu_pkg::data_bits-1:0] pc_plus;

    assign pc_plus = pc + cpu_pkg::inst_size;

    // Program load, done while reset is held
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr[imem_addr_bits-1:2]] <= prog_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc    <= start_pc;
            valid <= 1'b0;
        end else if (redirect) begin  // Wins over stall
            pc    <= target;
            valid <= 1'b0;              // Wrong-path word is dropped
        end else if (!stall) begin
            pc    <= pc_plus;
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            inst    <= imem[pc[imem_addr_bits-1:2]];
            next_pc <= pc_plus;
        end
    end
endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                            clk,
    input  logic                            reset,
    input  cpu_pkg::instr_t                 inst,
    input  logic [cpu_pkg::data_bits-1:0]   next_pc,
    input  logic                            valid,
    input  logic                            redirect,
    input  logic [cpu_pkg::data_bits-1:0]   ex_result,
    input  logic [cpu_pkg::reg_no_bits-1:0] ex_dst,
    input  logic                            ex_is_load,
    input  logic [cpu_pkg::data_bits-1:0]   mem_result,
    input  logic [cpu_pkg::reg_no_bits-1:0] mem_dst,
    input  logic                            wb_we,
    input  logic [cpu_pkg::reg_no_bits-1:0] wb_dst,
    input  logic [cpu_pkg::data_bits-1:0]   wb_data,
    output logic                            stall,
    output cpu_pkg::op1_t                   op1,
    output cpu_pkg::op2_t                   op2,
    output logic [cpu_pkg::data_bits-1:0]   rs_val,
    output logic [cpu_pkg::data_bits-1:0]   rt_val,
    output logic [cpu_pkg::data_bits-1:0]   imm_val,
    output logic [cpu_pkg::data_bits-1:0]   pc,
    output logic [cpu_pkg::reg_no_bits-1:0] dst,
    output logic                            reg_we,
    output logic                            mem_we,
    output cpu_pkg::wb_src_t                wb_src
);

    localparam int dw = cpu_pkg::data_bits;
    localparam int iw = cpu_pkg::imm_bits;

    cpu_pkg::op1_t                   op1_w;
    cpu_pkg::wb_src_t                wb_src_w;
    logic [cpu_pkg::reg_no_bits-1:0] rs_no;
    logic [cpu_pkg::reg_no_bits-1:0] rt_no;
    logic [cpu_pkg::reg_no_bits-1:0] dst_w;
    logic [dw-1:0]                   rs_reg;
    logic [dw-1:0]                   rt_reg;
    logic                            reg_we_w;
    logic                            mem_we_w;
    logic                            uses_rt;
    logic                            bubble;

    assign op1_w = inst.rtype.op1;
    assign rs_no = inst.rtype.rs;  // Same position in both formats
    assign rt_no = inst.rtype.rt;

    register_file i_register_file (
        .clk(clk), .reset(reset),
        .rs(rs_no), .rt(rt_no), .rs_val(rs_reg), .rt_val(rt_reg),
        .we(wb_we), .wdst(wb_dst), .wdata(wb_data)
    );

    always_comb begin
        reg_we_w = 1'b0;
        mem_we_w = 1'b0;
        uses_rt  = 1'b0;
        wb_src_w = cpu_pkg::wb_alu;
        case (op1_w)
            cpu_pkg::op1_alur: begin
                reg_we_w = 1'b1;
                uses_rt  = 1'b1;
            end
            cpu_pkg::op1_beq, cpu_pkg::op1_blt, cpu_pkg::op1_ble, cpu_pkg::op1_bne: uses_rt = 1'b1;
            cpu_pkg::op1_jal: begin
                reg_we_w = 1'b1;
                wb_src_w = cpu_pkg::wb_pc;
            end
            cpu_pkg::op1_lw: begin
                reg_we_w = 1'b1;
                wb_src_w = cpu_pkg::wb_mem;
            end
            cpu_pkg::op1_sw: begin
                mem_we_w = 1'b1;
                uses_rt  = 1'b1;  // Store data
            end
            cpu_pkg::op1_addi, cpu_pkg::op1_andi, cpu_pkg::op1_ori, cpu_pkg::op1_xori: reg_we_w = 1'b1;
            default: ;
        endcase
    end

    // Non-writers carry destination 0 down the pipe
    assign dst_w = !reg_we_w ? '0 : (op1_w == cpu_pkg::op1_alur) ? inst.rtype.rd : rt_no;

    // Loaded value is not ready until the load reaches MEM
    assign stall = valid && ex_is_load && ex_dst != '0 &&
                   (rs_no == ex_dst || (uses_rt && rt_no == ex_dst));
    assign bubble = !valid || stall || redirect;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op1    <= cpu_pkg::op1_alur;
            op2    <= cpu_pkg::op2_add;
            dst    <= '0;
            reg_we <= 1'b0;
            mem_we <= 1'b0;
            wb_src <= cpu_pkg::wb_alu;
        end else begin
            op1    <= bubble ? cpu_pkg::op1_alur : op1_w;
            op2    <= inst.rtype.op2;
            dst    <= bubble ? '0 : dst_w;
            reg_we <= reg_we_w && !bubble;
            mem_we <= mem_we_w && !bubble;
            wb_src <= wb_src_w;
        end
    end

    // Operands, EX first, then MEM, then the register file
    always_ff @(posedge clk) begin
        rs_val  <= (rs_no != '0 && rs_no == ex_dst) ? ex_result :
                   (rs_no != '0 && rs_no == mem_dst) ? mem_result : rs_reg;
        rt_val  <= (rt_no != '0 && rt_no == ex_dst) ? ex_result :
                   (rt_no != '0 && rt_no == mem_dst) ? mem_result : rt_reg;
        imm_val <= {{(dw - iw){inst.itype.imm[iw-1]}}, inst.itype.imm};
        pc      <= next_pc;
    end
endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                            clk,
    input  logic                            reset,
    input  cpu_pkg::op1_t                   id_op1,
    input  cpu_pkg::op2_t                   id_op2,
    input  logic [cpu_pkg::data_bits-1:0]   id_rs_val,
    input  logic [cpu_pkg::data_bits-1:0]   id_rt_val,
    input  logic [cpu_pkg::data_bits-1:0]   id_imm_val,
    input  logic [cpu_pkg::data_bits-1:0]   id_pc,
    input  logic [cpu_pkg::reg_no_bits-1:0] id_dst,
    input  logic                            id_reg_we,
    input  logic                            id_mem_we,
    input  cpu_pkg::wb_src_t                id_wb_src,
    output logic [cpu_pkg::data_bits-1:0]   result,
    output logic [cpu_pkg::reg_no_bits-1:0] dst_fwd,
    output logic                            is_load,
    output logic                            redirect,
    output logic [cpu_pkg::data_bits-1:0]   target,
    output logic [cpu_pkg::data_bits-1:0]   alu_out,
    output logic [cpu_pkg::data_bits-1:0]   store_data,
    output logic [cpu_pkg::data_bits-1:0]   pc,
    output logic [cpu_pkg::reg_no_bits-1:0] dst,
    output logic                            reg_we,
    output logic                            mem_we,
    output cpu_pkg::wb_src_t                wb_src
);

    localparam int dw = cpu_pkg::data_bits;

    logic [dw-1:0] operand_b;
    logic [dw-1:0] alu;
    logic          taken;
    logic          is_jal;

    assign operand_b = (id_op1 == cpu_pkg::op1_alur) ? id_rt_val : id_imm_val;

    always_comb begin
        alu = id_rs_val + operand_b;  // ADDI and memory address
        case (id_op1)
            cpu_pkg::op1_alur: begin
                case (id_op2)
                    cpu_pkg::op2_eq:   alu = {{(dw-1){1'b0}}, id_rs_val == operand_b};
                    cpu_pkg::op2_lt:   alu = {{(dw-1){1'b0}}, $signed(id_rs_val) < $signed(operand_b)};
                    cpu_pkg::op2_le:   alu = {{(dw-1){1'b0}}, $signed(id_rs_val) <= $signed(operand_b)};
                    cpu_pkg::op2_ne:   alu = {{(dw-1){1'b0}}, id_rs_val != operand_b};
                    cpu_pkg::op2_add:  alu = id_rs_val + operand_b;
                    cpu_pkg::op2_and:  alu = id_rs_val & operand_b;
                    cpu_pkg::op2_or:   alu = id_rs_val | operand_b;
                    cpu_pkg::op2_xor:  alu = id_rs_val ^ operand_b;
                    cpu_pkg::op2_sub:  alu = id_rs_val - operand_b;
                    cpu_pkg::op2_nand: alu = ~(id_rs_val & operand_b);
                    cpu_pkg::op2_nor:  alu = ~(id_rs_val | operand_b);
                    cpu_pkg::op2_nxor: alu = ~(id_rs_val ^ operand_b);
                    cpu_pkg::op2_rshf: alu = $signed(id_rs_val) >>> operand_b;  // Arithmetic
                    cpu_pkg::op2_lshf: alu = id_rs_val << operand_b;
                    default:           alu = '0;
                endcase
            end
            cpu_pkg::op1_andi: alu = id_rs_val & operand_b;
            cpu_pkg::op1_ori:  alu = id_rs_val | operand_b;
            cpu_pkg::op1_xori: alu = id_rs_val ^ operand_b;
            default: ;
        endcase
    end

    // Signed compare of rs against rt
    always_comb begin
        case (id_op1)
            cpu_pkg::op1_beq: taken = id_rs_val == id_rt_val;
            cpu_pkg::op1_blt: taken = $signed(id_rs_val) < $signed(id_rt_val);
            cpu_pkg::op1_ble: taken = $signed(id_rs_val) <= $signed(id_rt_val);
            cpu_pkg::op1_bne: taken = id_rs_val != id_rt_val;
            default:          taken = 1'b0;
        endcase
    end

    assign is_jal   = id_op1 == cpu_pkg::op1_jal;
    assign redirect = taken || is_jal;
    assign target   = (is_jal ? id_rs_val : id_pc) + (id_imm_val << 2);
    assign result   = is_jal ? id_pc : alu;  // JAL forwards its return address
    assign dst_fwd  = id_dst;
    assign is_load  = id_op1 == cpu_pkg::op1_lw;

    // Branches have no write enables and so become bubbles here
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dst    <= '0;
            reg_we <= 1'b0;
            mem_we <= 1'b0;
            wb_src <= cpu_pkg::wb_alu;
        end else begin
            dst    <= id_dst;
            reg_we <= id_reg_we;
            mem_we <= id_mem_we;
            wb_src <= id_wb_src;
        end
    end

    always_ff @(posedge clk) begin
        alu_out    <= alu;
        store_data <= id_rt_val;
        pc         <= id_pc;
    end
endmodule

// ==== logic/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage #(
    parameter int dmem_addr_bits = 16
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpu_pkg::data_bits-1:0]   alu_out,
    input  logic [cpu_pkg::data_bits-1:0]   store_data,
    input  logic [cpu_pkg::data_bits-1:0]   pc,
    input  logic [cpu_pkg::reg_no_bits-1:0] dst,
    input  logic                            reg_we,
    input  logic                            mem_we,
    input  cpu_pkg::wb_src_t                wb_src,
    mem_bus_if.master                       bus,
    output logic [cpu_pkg::data_bits-1:0]   fwd_value,
    output logic [cpu_pkg::reg_no_bits-1:0] fwd_dst,
    output logic                            wb_we,
    output logic [cpu_pkg::reg_no_bits-1:0] wb_dst,
    output logic [cpu_pkg::data_bits-1:0]   wb_data
);

    localparam int dw         = cpu_pkg::data_bits;
    localparam int dmem_words = 2 ** (dmem_addr_bits - 2);

    logic [dw-1:0] dmem [dmem_words];
    logic [dw-1:0] load_data;
    logic          is_io;

    // Whole top page goes to the devices
    assign is_io = alu_out[dw-1:12] == cpu_pkg::addr_hex[dw-1:12];

    assign bus.addr  = alu_out;
    assign bus.wdata = store_data;
    assign bus.we    = mem_we && is_io;

    always_ff @(posedge clk) begin
        if (mem_we && !is_io) begin
            dmem[alu_out[dmem_addr_bits-1:2]] <= store_data;
        end
    end

    assign load_data = is_io ? bus.rdata : dmem[alu_out[dmem_addr_bits-1:2]];

    always_comb begin
        case (wb_src)
            cpu_pkg::wb_pc:  fwd_value = pc;
            cpu_pkg::wb_mem: fwd_value = load_data;
            default:         fwd_value = alu_out;
        endcase
    end

    assign fwd_dst = dst;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_we  <= 1'b0;
            wb_dst <= '0;
        end else begin
            wb_we  <= reg_we;
            wb_dst <= dst;
        end
    end

    always_ff @(posedge clk) begin
        wb_data <= fwd_value;
    end
endmodule

// ==== logic/io_devices.sv ====
`timescale 1ns/1ps

module io_devices (
    input  logic                          clk,
    input  logic                          reset,
    mem_bus_if.device                     bus,
    input  logic [cpu_pkg::key_bits-1:0]  key,
    input  logic [cpu_pkg::sw_bits-1:0]   sw,
    output logic [cpu_pkg::ledr_bits-1:0] ledr,
    output logic [cpu_pkg::hex_bits-1:0]  hex
);

    localparam int dw = cpu_pkg::data_bits;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ledr <= '0;
            hex  <= cpu_pkg::hex_reset_value;
        end else if (bus.we) begin
            if (bus.addr == cpu_pkg::addr_ledr) begin
                ledr <= bus.wdata[cpu_pkg::ledr_bits-1:0];
            end
            if (bus.addr == cpu_pkg::addr_hex) begin
                hex <= bus.wdata[cpu_pkg::hex_bits-1:0];
            end
        end
    end

    always_comb begin
        case (bus.addr)
            cpu_pkg::addr_ledr: bus.rdata = {{(dw - cpu_pkg::ledr_bits){1'b0}}, ledr};
            cpu_pkg::addr_hex:  bus.rdata = {{(dw - cpu_pkg::hex_bits){1'b0}}, hex};
            cpu_pkg::addr_key:  bus.rdata = {{(dw - cpu_pkg::key_bits){1'b0}}, ~key};  // Keys are active low
            cpu_pkg::addr_sw:   bus.rdata = {{(dw - cpu_pkg::sw_bits){1'b0}}, sw};
            default:            bus.rdata = '0;
        endcase
    end
endmodule

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
    parameter int                            imem_addr_bits = 16,
    parameter int                            dmem_addr_bits = 16,
    parameter logic [cpu_pkg::data_bits-1:0] start_pc       = 32'h100
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          prog_we,
    input  logic [cpu_pkg::data_bits-1:0] prog_addr,
    input  logic [cpu_pkg::data_bits-1:0] prog_data,
    input  logic [cpu_pkg::key_bits-1:0]  key,
    input  logic [cpu_pkg::sw_bits-1:0]   sw,
    output logic [cpu_pkg::ledr_bits-1:0] ledr,
    output logic [cpu_pkg::hex_bits-1:0]  hex
);

    localparam int dw = cpu_pkg::data_bits;
    localparam int rw = cpu_pkg::reg_no_bits;

    cpu_pkg::instr_t  fe_inst;
    logic [dw-1:0]    fe_next_pc;
    logic             fe_valid;
    logic             stall;
    logic             redirect;
    logic [dw-1:0]    target;

    // Forwarding sources
    logic [dw-1:0]    ex_result;
    logic [rw-1:0]    ex_fwd_dst;
    logic             ex_is_load;
    logic [dw-1:0]    mem_fwd_value;
    logic [rw-1:0]    mem_fwd_dst;

    // Decode latch
    cpu_pkg::op1_t    id_op1;
    cpu_pkg::op2_t    id_op2;
    logic [dw-1:0]    id_rs_val;
    logic [dw-1:0]    id_rt_val;
    logic [dw-1:0]    id_imm_val;
    logic [dw-1:0]    id_pc;
    logic [rw-1:0]    id_dst;
    logic             id_reg_we;
    logic             id_mem_we;
    cpu_pkg::wb_src_t id_wb_src;

    // Execute latch
    logic [dw-1:0]    ex_alu_out;
    logic [dw-1:0]    ex_store_data;
    logic [dw-1:0]    ex_pc;
    logic [rw-1:0]    ex_dst;
    logic             ex_reg_we;
    logic             ex_mem_we;
    cpu_pkg::wb_src_t ex_wb_src;

    // Register write port
    logic             wb_we;
    logic [rw-1:0]    wb_dst;
    logic [dw-1:0]    wb_data;

    mem_bus_if bus ();

    fetch_stage #(.imem_addr_bits(imem_addr_bits), .start_pc(start_pc)) i_fetch_stage (
        .clk(clk), .reset(reset), .stall(stall), .redirect(redirect), .target(target),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .inst(fe_inst), .next_pc(fe_next_pc), .valid(fe_valid)
    );

    decode_stage i_decode_stage (
        .clk(clk), .reset(reset),
        .inst(fe_inst), .next_pc(fe_next_pc), .valid(fe_valid), .redirect(redirect),
        .ex_result(ex_result), .ex_dst(ex_fwd_dst), .ex_is_load(ex_is_load),
        .mem_result(mem_fwd_value), .mem_dst(mem_fwd_dst),
        .wb_we(wb_we), .wb_dst(wb_dst), .wb_data(wb_data), .stall(stall),
        .op1(id_op1), .op2(id_op2), .rs_val(id_rs_val), .rt_val(id_rt_val),
        .imm_val(id_imm_val), .pc(id_pc), .dst(id_dst),
        .reg_we(id_reg_we), .mem_we(id_mem_we), .wb_src(id_wb_src)
    );

    execute_stage i_execute_stage (
        .clk(clk), .reset(reset),
        .id_op1(id_op1), .id_op2(id_op2), .id_rs_val(id_rs_val), .id_rt_val(id_rt_val),
        .id_imm_val(id_imm_val), .id_pc(id_pc), .id_dst(id_dst),
        .id_reg_we(id_reg_we), .id_mem_we(id_mem_we), .id_wb_src(id_wb_src),
        .result(ex_result), .dst_fwd(ex_fwd_dst), .is_load(ex_is_load),
        .redirect(redirect), .target(target),
        .alu_out(ex_alu_out), .store_data(ex_store_data), .pc(ex_pc), .dst(ex_dst),
        .reg_we(ex_reg_we), .mem_we(ex_mem_we), .wb_src(ex_wb_src)
    );

    memory_stage #(.dmem_addr_bits(dmem_addr_bits)) i_memory_stage (
        .clk(clk), .reset(reset),
        .alu_out(ex_alu_out), .store_data(ex_store_data), .pc(ex_pc), .dst(ex_dst),
        .reg_we(ex_reg_we), .mem_we(ex_mem_we), .wb_src(ex_wb_src), .bus(bus.master),
        .fwd_value(mem_fwd_value), .fwd_dst(mem_fwd_dst),
        .wb_we(wb_we), .wb_dst(wb_dst), .wb_data(wb_data)
    );

    io_devices i_io_devices (
        .clk(clk), .reset(reset), .bus(bus.device),
        .key(key), .sw(sw), .ledr(ledr), .hex(hex)
    );
endmodule

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

    localparam logic [31:0] start_pc     = 32'h100;
    localparam logic [23:0] hex_at_reset = 24'hFEDEAD;
    localparam int          pat_words    = 512;
    localparam int          poll_limit   = 500;
    localparam int          hold_cycles  = 20;

    logic        clk;
    logic        reset;
    logic        prog_we;
    logic [31:0] prog_addr;
    logic [31:0] prog_data;
    logic [3:0]  key;
    logic [9:0]  sw;
    logic [9:0]  ledr;
    logic [23:0] hex;

    logic [31:0] pat [pat_words];  // Raw words of the patterns file
    int          errors;
    int          checks;

    cpu_top #(
        .start_pc(start_pc)
    ) i_cpu_top (
        .clk(clk),
        .reset(reset),
        .prog_we(prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .key(key),
        .sw(sw),
        .ledr(ledr),
        .hex(hex)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;  // 100 ns period

    // Inputs change 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_program(input int base, input int count);
        for (int i = 0; i < count; i++) begin
            prog_we   = 1'b1;
            prog_addr = start_pc + (i << 2);
            prog_data = pat[base + i];
            step_cycle();
        end
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
    endtask

    task automatic check_reset_values(input int test_no);
        @(negedge clk);
        checks++;
        if (ledr !== 10'h000 || hex !== hex_at_reset) begin
            errors++;
            $display("[FAIL] %0t: test %0d in reset, ledr %h hex %h, expected 000 %h",
                     $time, test_no, ledr, hex, hex_at_reset);
        end
    endtask

    // One block of the patterns file, p moves past it
    task automatic run_test(input int test_no, inout int p);
        int          count;
        int          cycles;
        logic [3:0]  key_val;
        logic [9:0]  sw_val;
        logic [9:0]  exp_ledr;
        logic [23:0] exp_hex;
        bit          matched;
        bit          stray;

        count    = pat[p];
        key_val  = pat[p + count + 1][3:0];
        sw_val   = pat[p + count + 2][9:0];
        exp_ledr = pat[p + count + 3][9:0];
        exp_hex  = pat[p + count + 4][23:0];
        $display("Test %0d with %0d program words", test_no, count);

        step_cycle();
        reset = 1'b1;
        repeat (4) step_cycle();
        load_program(p + 1, count);  // Still in reset
        check_reset_values(test_no);
        step_cycle();
        key = key_val;
        sw  = sw_val;
        step_cycle();
        reset = 1'b0;

        // Each program writes LEDR and HEX once, so any other value is a stray store
        matched = 1'b0;
        stray   = 1'b0;
        cycles  = 0;
        while (!matched && !stray && cycles < poll_limit) begin
            @(negedge clk);
            cycles++;
            checks++;
            if (ledr === exp_ledr && hex === exp_hex) begin
                matched = 1'b1;
            end else if ((ledr !== 10'h000 && ledr !== exp_ledr) ||
                         (hex !== hex_at_reset && hex !== exp_hex)) begin
                stray = 1'b1;
                errors++;
                $display("[FAIL] %0t: test %0d unexpected ledr %h hex %h, expected %h %h",
                         $time, test_no, ledr, hex, exp_ledr, exp_hex);
            end
        end
        if (!matched && !stray) begin
            errors++;
            $display("Test %0d timed out after %0d cycles waiting for ledr %h and hex %h",
                     test_no, poll_limit, exp_ledr, exp_hex);
        end

        if (matched) begin
            cycles = 0;
            while (!stray && cycles < hold_cycles) begin
                @(negedge clk);
                cycles++;
                checks++;
                if (ledr !== exp_ledr || hex !== exp_hex) begin
                    stray = 1'b1;
                    errors++;
                    $display("[FAIL] %0t: test %0d output moved to ledr %h hex %h from %h %h",
                             $time, test_no, ledr, hex, exp_ledr, exp_hex);
                end
            end
        end
        p = p + count + 5;
    endtask

    initial begin
        int p;
        int test_no;

        $timeformat(-9, 0, " ns", 0);
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        key       = 4'hF;  // No key pressed
        sw        = '0;
        errors    = 0;
        checks    = 0;
        p         = 0;
        test_no   = 0;

        $readmemh("bench/cpu_patterns.txt", pat);
        while (p < pat_words - 5 && !$isunknown(pat[p]) && pat[p] != 0) begin
            test_no++;
            run_test(test_no, p);
        end
        if (test_no == 0) begin
            errors++;
            $display("No tests could be read from bench/cpu_patterns.txt");
        end

        $display("%0d tests, %0d checks, %0d errors", test_no, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end
endmodule

// ==== bench/cpu_patterns.txt ====
// Per test: word count, program words stored from address 100, then key and sw,
// then expected ledr and hex. A count of 0 ends the list. All values are hex.

// ALU chain with forwarding, all function codes and immediate operations
00000021
80123401 940F0F12 98FF0023 907FF034 00800541 00A00652 00900763 00940874
00980985 00B00A92 00B40BA1 00B80CB9 00C00DCB 00C40EDB 00200FEE 002401EF
00280210 002C032F 00800431 0080044F 00800449 0080044D 0080044E 0080044A
0080044C 00800447 00800448 00800446 00800445 0080044B 68F02004 68F00004
20FFFF00
0000000F 00000000
0000005A 0001385A

// Store then load, load-use stalls on an operand and on store data
0000000A
80012301 80004002 68000021 48000023 80000134 68F02004 68000424 48000425
68F00005 20FFFF00
0000000F 00000000
00000124 00000124

// Taken and not-taken branches on negative values, JAL return address to HEX
00000022
80FFFB01 80FFFD02 8003FF03 20000212 94000144 24000212 68F02003 68F02003
94000244 24000221 94000444 28000211 68F02003 68F02003 94000844 28000221
94001044 2C000212 68F02003 68F02003 94002044 2C000211 94004044 20000222
68F02003 68F02003 94008044 30005E05 68F02003 68F02003 94010044 68F00005
68F02004 20FFFF00
0000000F 00000000
000001FF 00000170

// KEY and SW reads
00000006
48F08001 48F09002 00800312 68F02002 68F00003 20FFFF00
0000000A 000002A5
000002A5 000002AA

00000000

// ==== sources.f ====
logic/cpu_pkg.sv
logic/mem_bus_if.sv
logic/register_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/io_devices.sv
logic/cpu_top.sv
bench/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_pipeline

sources:
  - logic/cpu_pkg.sv
  - logic/mem_bus_if.sv
  - logic/register_file.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/memory_stage.sv
  - logic/io_devices.sv
  - logic/cpu_top.sv
  - target: test
    files:
      - bench/cpu_tb.sv
